// File: Makefile
# Verilator flow for the fetch unit testbench
SIM        := verilator
TOP        := fetch_unit_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := CHECKS FAILED
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
RUN_ARGS   := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/fetch_defines.svh
// fetch unit widths and constants
// line geometry, queue and stack sizes, reset and trap vectors
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ------------------------------
// datapath widths
// ------------------------------
`define FETCH_PC_SZ         32                         // program counter width
`define FETCH_XLEN          32                         // instruction width
`define FETCH_CL_BYTES      32                         // bytes per cache line
`define FETCH_CL_SZ         ($clog2(`FETCH_CL_BYTES))  // byte offset bits in a line
`define FETCH_MAX_IPCL      8                          // 32-bit instructions per line

// ------------------------------
// storage depths, powers of two
// ------------------------------
`define FETCH_Q_DEPTH       16
`define FETCH_RAS_DEPTH     8
`define FETCH_QCNT_SZ       ($clog2(`FETCH_Q_DEPTH) + 1)    // queue count, 0..depth
`define FETCH_WCNT_SZ       ($clog2(`FETCH_MAX_IPCL) + 1)   // writes per line, 0..ipcl

// fixed addresses
`define FETCH_RESET_VECTOR  32'h0000_0000   // first fetch after reset
`define FETCH_TRAP_VECTOR   32'h0000_0200   // ecall / ebreak target

`endif

// File: hdl/fetch_pkg.sv
// types shared by the fetch unit and its testbench
// fsm states, branch classes, stack ops and the queue entry
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

   // ------------------------------
   // state and opcode enums
   // ------------------------------
   typedef enum logic [1:0] {
      LF_IDLE,                   // ready to request a line
      LF_WAIT,                   // request out, line will be used
      LF_STALE                   // request out, line will be dropped
   } line_fsm_t;

   typedef enum logic [2:0] {
      BR_NONE  = 3'd0,           // not a control transfer
      BR_JALR  = 3'd1,
      BR_COND  = 3'd2,           // beq, bne, blt ...
      BR_JAL   = 3'd3,
      BR_RET   = 3'd4,           // mret
      BR_TRAP  = 3'd5            // ecall, ebreak
   } br_type_t;

   typedef enum logic [1:0] {
      RAS_NONE,
      RAS_PUSH,
      RAS_POP,
      RAS_POP_PUSH               // top entry replaced
   } ras_op_t;

   // ------------------------------
   // bundles
   // ------------------------------
   typedef struct packed {
      logic [`FETCH_PC_SZ-1:0]   pc;
      logic [`FETCH_XLEN-1:0]    instruction;
      logic [`FETCH_PC_SZ-1:0]   predicted_addr;    // where fetch went after this one
   } fetch_entry_t;

   typedef struct packed {
      ras_op_t                   op;
      logic [`FETCH_PC_SZ-1:0]   push_addr;         // return address, pc + 4
   } ras_cmd_t;

endpackage

`default_nettype wire

// File: hdl/fetch_unit.sv
// instruction fetch unit top
// line requests to the i-cache, predecode, return stack and queue to decode
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_unit (
   input  logic                            clk_in,
   input  logic                            reset_in,
   input  logic                            cpu_halt,
   input  logic                            pc_reload,
   input  logic [`FETCH_PC_SZ-1:0]         pc_reload_addr,
   // i-cache
   output logic                            ic_req,
   output logic [`FETCH_PC_SZ-1:0]         ic_addr,
   input  logic                            ic_ack,
   input  logic [`FETCH_CL_BYTES*8-1:0]    ic_line,
   // decode
   output logic                            f2d_valid,
   output fetch_pkg::fetch_entry_t         f2d_entry,
   input  logic                            f2d_rdy
);
   // ------------------------------
   // internal nets
   // ------------------------------
   logic                                           line_accept;
   logic [`FETCH_PC_SZ-1:0]                        next_fetch_pc;
   logic                                           q_full;
   logic [`FETCH_QCNT_SZ-1:0]                      free_slots;
   logic [`FETCH_WCNT_SZ-1:0]                      wr_count;
   fetch_pkg::fetch_entry_t [`FETCH_MAX_IPCL-1:0]  wr_entries;
   fetch_pkg::ras_cmd_t                            ras_cmd;
   logic [`FETCH_PC_SZ-1:0]                        ras_top;

   line_request_fsm u_line_request_fsm (
      .clk_in         (clk_in),
      .reset_in       (reset_in),
      .cpu_halt       (cpu_halt),
      .pc_reload      (pc_reload),
      .pc_reload_addr (pc_reload_addr),
      .ic_ack         (ic_ack),
      .q_full         (q_full),
      .next_fetch_pc  (next_fetch_pc),
      .ic_req         (ic_req),
      .line_pc        (ic_addr),              // cache address is the pc
      .line_accept    (line_accept)
   );

   line_predecoder u_line_predecoder (
      .line_pc        (ic_addr),
      .line_accept    (line_accept),
      .ic_line        (ic_line),
      .free_slots     (free_slots),
      .ras_top        (ras_top),
      .next_fetch_pc  (next_fetch_pc),
      .ras_cmd        (ras_cmd),
      .wr_count       (wr_count),
      .wr_entries     (wr_entries)
   );

   return_addr_stack u_return_addr_stack (
      .clk_in         (clk_in),
      .reset_in       (reset_in),
      .ras_cmd        (ras_cmd),
      .ras_top        (ras_top)
   );

   instr_queue u_instr_queue (
      .clk_in         (clk_in),
      .reset_in       (reset_in),
      .pc_reload      (pc_reload),
      .wr_count       (wr_count),
      .wr_entries     (wr_entries),
      .f2d_rdy        (f2d_rdy),
      .f2d_valid      (f2d_valid),
      .f2d_entry      (f2d_entry),
      .free_slots     (free_slots),
      .q_full         (q_full)
   );

endmodule

`default_nettype wire

// File: hdl/instr_queue.sv
// circular instruction queue between predecode and decode
// takes up to a line of entries per cycle, hands out one per handshake
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module instr_queue (
   input  logic                                           clk_in,
   input  logic                                           reset_in,
   input  logic                                           pc_reload,   // flush
   input  logic [`FETCH_WCNT_SZ-1:0]                      wr_count,
   input  fetch_pkg::fetch_entry_t [`FETCH_MAX_IPCL-1:0]  wr_entries,
   input  logic                                           f2d_rdy,
   output logic                                           f2d_valid,
   output fetch_pkg::fetch_entry_t                        f2d_entry,
   output logic [`FETCH_QCNT_SZ-1:0]                      free_slots,
   output logic                                           q_full
);
   localparam int QP_SZ = $clog2(`FETCH_Q_DEPTH);
   localparam int QC_SZ = `FETCH_QCNT_SZ;

   fetch_pkg::fetch_entry_t [`FETCH_Q_DEPTH-1:0] que;
   logic [QP_SZ-1:0]                            qip;     // input pointer
   logic [QP_SZ-1:0]                            qop;     // output pointer
   logic [QC_SZ-1:0]                            qcnt;    // entries held
   logic                                        rd_xfer;

   // ------------------------------
   // decode side
   // ------------------------------
   assign f2d_valid  = (qcnt != '0);
   assign f2d_entry  = que[qop];                  // holds until the pointer moves
   assign rd_xfer    = f2d_valid & f2d_rdy;

   // space left for the predecoder walk
   assign free_slots = QC_SZ'(`FETCH_Q_DEPTH) - qcnt;
   assign q_full     = (qcnt == QC_SZ'(`FETCH_Q_DEPTH));

   // ------------------------------
   // pointers and count
   // ------------------------------
   always_ff @(posedge clk_in)
   begin
      if (reset_in || pc_reload)
      begin
         qip  <= '0;
         qop  <= '0;
         qcnt <= '0;
      end
      else
      begin
         qip  <= qip + QP_SZ'(wr_count);
         qop  <= qop + QP_SZ'(rd_xfer);
         qcnt <= qcnt + QC_SZ'(wr_count) - QC_SZ'(rd_xfer);   // write and read together
      end
   end

   // entry storage
   always_ff @(posedge clk_in)
   begin
      for (int k = 0; k < `FETCH_MAX_IPCL; k++)
      begin
         if (k < int'(wr_count))
            que[qip + QP_SZ'(k)] <= wr_entries[k];    // lands in free slots only
      end
   end

endmodule

`default_nettype wire

// File: hdl/line_predecoder.sv
// one-cycle walk over a returned cache line
// classifies each instruction, predicts its successor and builds queue writes
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module line_predecoder (
   input  logic [`FETCH_PC_SZ-1:0]                        line_pc,
   input  logic                                           line_accept,
   input  logic [`FETCH_CL_BYTES*8-1:0]                   ic_line,
   input  logic [`FETCH_QCNT_SZ-1:0]                      free_slots,
   input  logic [`FETCH_PC_SZ-1:0]                        ras_top,
   output logic [`FETCH_PC_SZ-1:0]                        next_fetch_pc,
   output fetch_pkg::ras_cmd_t                            ras_cmd,
   output logic [`FETCH_WCNT_SZ-1:0]                      wr_count,
   output fetch_pkg::fetch_entry_t [`FETCH_MAX_IPCL-1:0]  wr_entries
);
   localparam int SLOT_SZ = $clog2(`FETCH_MAX_IPCL);
   localparam int QC_SZ   = `FETCH_QCNT_SZ;
   localparam int PC_SZ   = `FETCH_PC_SZ;
   localparam int XLEN    = `FETCH_XLEN;

   // system encodings recognised whole
   localparam logic [XLEN-1:0] MRET_I   = 32'h3020_0073;
   localparam logic [XLEN-1:0] ECALL_I  = 32'h0000_0073;
   localparam logic [XLEN-1:0] EBREAK_I = 32'h0010_0073;

   logic [SLOT_SZ-1:0]     start_slot;          // first requested slot in the line
   logic [XLEN-1:0]        instr;
   logic                   is32;
   fetch_pkg::br_type_t    btype;
   logic [PC_SZ-1:0]       b_imm, j_imm, i_imm;
   logic [4:0]             rd, rs1;
   logic                   link_rd, link_rs1;  // x1 / x5 hints
   logic [PC_SZ-1:0]       cur_pc, seq_pc, pred_pc;
   logic                   taken;
   logic                   done;

   assign start_slot = line_pc[`FETCH_CL_SZ-1:2];

   always_comb
   begin
      wr_entries         = '0;
      wr_count           = '0;
      ras_cmd.op         = fetch_pkg::RAS_NONE;
      ras_cmd.push_addr  = '0;
      next_fetch_pc      = line_pc;             // idle: no change of direction
      cur_pc             = line_pc;
      done               = !line_accept;
      instr              = '0;
      is32               = 1'b0;
      btype              = fetch_pkg::BR_NONE;
      b_imm              = '0;
      j_imm              = '0;
      i_imm              = '0;
      rd                 = '0;
      rs1                = '0;
      link_rd            = 1'b0;
      link_rs1           = 1'b0;
      seq_pc             = '0;
      pred_pc            = '0;
      taken              = 1'b0;

      for (int c = 0; c < `FETCH_MAX_IPCL; c++)
      begin
         if (!done && (c >= int'(start_slot)))
         begin
            // ------------------------------
            // size and class
            // ------------------------------
            instr = ic_line[c*XLEN +: XLEN];
            is32  = (instr[1:0] == 2'b11) && (instr[4:2] != 3'b111);
            btype = fetch_pkg::BR_NONE;
            if (is32)
            begin
               case (instr[6:2])
                  5'b11000: btype = fetch_pkg::BR_COND;
                  5'b11001:
                  begin
                     if (instr[14:12] == 3'b000)
                        btype = fetch_pkg::BR_JALR;
                  end
                  5'b11011: btype = fetch_pkg::BR_JAL;
                  default:  btype = fetch_pkg::BR_NONE;
               endcase
               if (instr == MRET_I)
                  btype = fetch_pkg::BR_RET;
               if ((instr == ECALL_I) || (instr == EBREAK_I))
                  btype = fetch_pkg::BR_TRAP;
            end

            b_imm    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            j_imm    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            i_imm    = {{21{instr[31]}}, instr[30:20]};
            rd       = instr[11:7];
            rs1      = instr[19:15];
            link_rd  = (rd == 5'd1) || (rd == 5'd5);
            link_rs1 = (rs1 == 5'd1) || (rs1 == 5'd5);

            // ------------------------------
            // prediction
            // ------------------------------
            seq_pc  = cur_pc + PC_SZ'(4);
            pred_pc = seq_pc;
            taken   = 1'b0;
            case (btype)
               fetch_pkg::BR_COND:
               begin
                  taken = b_imm[PC_SZ-1];        // backward taken, forward not
                  if (taken)
                     pred_pc = cur_pc + b_imm;
               end
               fetch_pkg::BR_JAL:
               begin
                  taken   = 1'b1;
                  pred_pc = cur_pc + j_imm;
                  if (link_rd)
                     ras_cmd.op = fetch_pkg::RAS_PUSH;
               end
               fetch_pkg::BR_JALR:
               begin
                  taken   = 1'b1;
                  pred_pc = i_imm;                // rs1 guessed as x0
                  case ({link_rd, link_rs1})
                     2'b10:   ras_cmd.op = fetch_pkg::RAS_PUSH;
                     2'b01:   ras_cmd.op = fetch_pkg::RAS_POP;
                     2'b11:   ras_cmd.op = (rd == rs1) ? fetch_pkg::RAS_PUSH
                                                       : fetch_pkg::RAS_POP_PUSH;
                     default: ras_cmd.op = fetch_pkg::RAS_NONE;
                  endcase
               end
               fetch_pkg::BR_RET:
               begin
                  taken      = 1'b1;
                  pred_pc    = ras_top;
                  ras_cmd.op = fetch_pkg::RAS_POP;
               end
               fetch_pkg::BR_TRAP:
               begin
                  taken   = 1'b1;
                  pred_pc = `FETCH_TRAP_VECTOR;
               end
               default: taken = 1'b0;
            endcase
            ras_cmd.push_addr = seq_pc;           // only read when op pushes

            // queue write for this slot
            wr_entries[wr_count[SLOT_SZ-1:0]].pc             = cur_pc;
            wr_entries[wr_count[SLOT_SZ-1:0]].instruction    = instr;
            wr_entries[wr_count[SLOT_SZ-1:0]].predicted_addr = pred_pc;
            wr_count      = wr_count + 1'b1;
            next_fetch_pc = pred_pc;
            cur_pc        = pred_pc;

            // stop conditions
            if (taken || !is32)
               done = 1'b1;
            if (QC_SZ'(wr_count) == free_slots)
               done = 1'b1;                        // queue space used up
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/line_request_fsm.sv
// cache line request control
// holds the pc, a pending reload target and the last predicted address
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module line_request_fsm (
   input  logic                       clk_in,
   input  logic                       reset_in,
   input  logic                       cpu_halt,          // drop arriving lines
   input  logic                       pc_reload,         // redirect pulse
   input  logic [`FETCH_PC_SZ-1:0]    pc_reload_addr,
   input  logic                       ic_ack,
   input  logic                       q_full,
   input  logic [`FETCH_PC_SZ-1:0]    next_fetch_pc,     // from the predecoder walk
   output logic                       ic_req,
   output logic [`FETCH_PC_SZ-1:0]    line_pc,
   output logic                       line_accept
);
   fetch_pkg::line_fsm_t         state;
   logic [`FETCH_PC_SZ-1:0]      pc;                  // address of the line in flight
   logic                         reload_pend;         // redirect not yet requested
   logic [`FETCH_PC_SZ-1:0]      reload_addr;
   logic [`FETCH_PC_SZ-1:0]      last_pred;           // where the next request goes
   logic [`FETCH_PC_SZ-1:0]      req_addr;

   assign line_pc     = pc;                           // steady while ic_req is up
   assign line_accept = (state == fetch_pkg::LF_WAIT) && ic_req && ic_ack
                        && !cpu_halt && !pc_reload;

   // a pending redirect wins over the predicted address
   assign req_addr    = reload_pend ? reload_addr : last_pred;

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         state       <= fetch_pkg::LF_IDLE;
         ic_req      <= 1'b0;
         pc          <= `FETCH_RESET_VECTOR;
         reload_pend <= 1'b0;
         reload_addr <= '0;
         last_pred   <= `FETCH_RESET_VECTOR;
      end
      else
      begin
         if (pc_reload)
         begin
            reload_pend <= 1'b1;
            reload_addr <= pc_reload_addr;
         end

         // ------------------------------
         // request state machine
         // ------------------------------
         case (state)
            fetch_pkg::LF_IDLE:
            begin
               if (!q_full && !pc_reload)
               begin
                  ic_req      <= 1'b1;
                  state       <= fetch_pkg::LF_WAIT;
                  pc          <= req_addr;
                  reload_pend <= 1'b0;             // redirect consumed
               end
            end
            fetch_pkg::LF_WAIT:
            begin
               if (ic_ack)
               begin
                  ic_req    <= 1'b0;
                  state     <= fetch_pkg::LF_IDLE;
                  last_pred <= next_fetch_pc;      // line_pc again if the line was dropped
               end
               else if (pc_reload)
                  state <= fetch_pkg::LF_STALE;
            end
            default:                               // stale line, thrown away on ack
            begin
               if (ic_ack)
               begin
                  ic_req <= 1'b0;
                  state  <= fetch_pkg::LF_IDLE;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/return_addr_stack.sv
// return address stack for call / return prediction
// circular, wraps silently on overflow and underflow
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module return_addr_stack (
   input  logic                       clk_in,
   input  logic                       reset_in,
   input  fetch_pkg::ras_cmd_t        ras_cmd,     // from the accepted line
   output logic [`FETCH_PC_SZ-1:0]    ras_top
);
   localparam int PTR_SZ = $clog2(`FETCH_RAS_DEPTH);

   logic [`FETCH_RAS_DEPTH-1:0][`FETCH_PC_SZ-1:0] stack;
   logic [PTR_SZ-1:0]                             ptr;       // next free entry
   logic [PTR_SZ-1:0]                             top_ptr;

   assign top_ptr = ptr - 1'b1;                   // wraps with the pointer
   assign ras_top = stack[top_ptr];

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         ptr   <= '0;
         stack <= '0;
      end
      else
      begin
         case (ras_cmd.op)
            fetch_pkg::RAS_PUSH:
            begin
               stack[ptr] <= ras_cmd.push_addr;
               ptr        <= ptr + 1'b1;
            end
            fetch_pkg::RAS_POP:
               ptr <= top_ptr;
            fetch_pkg::RAS_POP_PUSH:
               stack[top_ptr] <= ras_cmd.push_addr;   // same depth, new top
            default:
               ptr <= ptr;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/line_request_fsm.sv
hdl/line_predecoder.sv
hdl/return_addr_stack.sv
hdl/instr_queue.sv
hdl/fetch_unit.sv
tb/fetch_unit_checker.sv
tb/fetch_unit_tb.sv

// File: tb/fetch_unit_checker.sv
// protocol checks bound onto the fetch unit ports
// cache request hold, decode back-pressure hold, idle outputs after reset
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_unit_checker (
   input  logic                       clk_in,
   input  logic                       reset_in,
   input  logic                       pc_reload,
   input  logic                       ic_req,
   input  logic [`FETCH_PC_SZ-1:0]    ic_addr,
   input  logic                       ic_ack,
   input  logic                       f2d_valid,
   input  logic                       f2d_rdy,
   input  fetch_pkg::fetch_entry_t    f2d_entry
);
   int assert_fails = 0;            // read by the testbench at the end

   // request stays up, address steady, until the cache acks
   req_held: assert property (@(posedge clk_in) disable iff (reset_in)
      ic_req && !ic_ack |=> ic_req && $stable(ic_addr))
      else
      begin
         $error("ic_req dropped or ic_addr moved before ic_ack");
         assert_fails++;
      end

   // one transfer per request
   req_drop: assert property (@(posedge clk_in) disable iff (reset_in)
      ic_req && ic_ack |=> !ic_req)
      else
      begin
         $error("ic_req still high after the transfer cycle");
         assert_fails++;
      end

   // entry held while decode stalls, a flush may drop it
   entry_held: assert property (@(posedge clk_in) disable iff (reset_in)
      f2d_valid && !f2d_rdy && !pc_reload |=> f2d_valid && $stable(f2d_entry))
      else
      begin
         $error("f2d_entry changed under back-pressure");
         assert_fails++;
      end

   outs_idle: assert property (@(posedge clk_in)
      reset_in |=> !ic_req && !f2d_valid)
      else
      begin
         $error("ic_req or f2d_valid high right after reset");
         assert_fails++;
      end

endmodule

bind fetch_unit fetch_unit_checker u_checker (
   .clk_in    (clk_in),
   .reset_in  (reset_in),
   .pc_reload (pc_reload),
   .ic_req    (ic_req),
   .ic_addr   (ic_addr),
   .ic_ack    (ic_ack),
   .f2d_valid (f2d_valid),
   .f2d_rdy   (f2d_rdy),
   .f2d_entry (f2d_entry)
);

`default_nettype wire

// File: tb/fetch_unit_tb.sv
// fetch unit testbench
// random program behind a cache model, reference walk of the same program, stream compare
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_unit_tb;

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DLY   = 10;                 // inputs move after the edge
   localparam int RESET_CYC   = 16;
   localparam int N_ENTRIES   = 400;                // entries compared per run
   localparam int CYCLE_LIMIT = N_ENTRIES * 10;     // ten cycles per entry at most
   localparam int RELOAD_GAP  = 90;                 // entries between redirects
   localparam int PC_SZ       = `FETCH_PC_SZ;
   localparam int MEM_WORDS   = 256;                // 1 KB program
   localparam int RP_SZ       = $clog2(`FETCH_RAS_DEPTH);
   localparam logic [31:0] SEED     = 32'h8f98_6071;
   localparam logic [31:0] MRET_W   = 32'h3020_0073;
   localparam logic [31:0] ECALL_W  = 32'h0000_0073;
   localparam logic [31:0] EBREAK_W = 32'h0010_0073;

   logic                               clk_in;
   logic                               reset_in;
   logic                               cpu_halt;
   logic                               pc_reload;
   logic [PC_SZ-1:0]                   pc_reload_addr;
   logic                               ic_req;
   logic [PC_SZ-1:0]                   ic_addr;
   logic                               ic_ack;
   logic [`FETCH_CL_BYTES*8-1:0]       ic_line;
   logic                               f2d_valid;
   fetch_pkg::fetch_entry_t            f2d_entry;
   logic                               f2d_rdy;

   integer            seed;
   logic [31:0]       prog [MEM_WORDS];            // program memory behind the cache
   logic [PC_SZ-1:0]  model_pc;                    // next pc the model expects
   logic [PC_SZ-1:0]  ras_model [`FETCH_RAS_DEPTH];
   logic [RP_SZ-1:0]  ras_ptr;
   int                errors, checks, entries, cycles;
   int                ack_delay, halt_left, next_reload;
   bit                draining, timed_out;

   fetch_unit u_fetch_unit (
      .clk_in         (clk_in),
      .reset_in       (reset_in),
      .cpu_halt       (cpu_halt),
      .pc_reload      (pc_reload),
      .pc_reload_addr (pc_reload_addr),
      .ic_req         (ic_req),
      .ic_addr        (ic_addr),
      .ic_ack         (ic_ack),
      .ic_line        (ic_line),
      .f2d_valid      (f2d_valid),
      .f2d_entry      (f2d_entry),
      .f2d_rdy        (f2d_rdy)
   );

   always #(CLK_PERIOD/2) clk_in = ~clk_in;

   // ------------------------------
   // random program
   // ------------------------------
   function automatic int unsigned pick(input int unsigned n);
      logic [31:0] r;
      r = $random(seed);
      return r % n;
   endfunction

   function automatic logic [4:0] pick_reg();   // mostly link registers and x0
      logic [4:0] r;
      case (pick(4))
         0:       r = 5'd0;
         1:       r = 5'd1;
         2:       r = 5'd5;
         default: r = 5'(pick(32));
      endcase
      return r;
   endfunction

   function automatic logic [31:0] make_word(input int idx);
      logic [31:0] w, off, tgt;
      logic [2:0]  f3;
      int unsigned kind;
      kind = pick(16);
      tgt  = 32'(pick(MEM_WORDS)) << 2;            // any word in memory
      off  = tgt - 32'(idx * 4);
      f3   = 3'(pick(6));
      if (f3 >= 3'd2)
         f3 = f3 + 3'd2;                           // skip the two unused branch codes
      case (kind)
         7, 8, 9:
         begin
            if ((kind == 9) || (idx == 0))
               off = 32'(1 + pick(16)) << 2;      // forward, never followed
            else
               off = (32'(pick(idx)) << 2) - 32'(idx * 4);   // backward into memory
            w = {off[12], off[10:5], 5'(pick(32)), 5'(pick(32)), f3, off[4:1], off[11], 7'h63};
         end
         10:      w = {off[20], off[10:1], off[11], off[19:12], (pick(2) ? 5'd1 : 5'd0), 7'h6f};
         11, 12:  w = {tgt[11:0], pick_reg(), 3'b000, pick_reg(), 7'h67};   // jalr imm target
         13:      w = MRET_W;
         14:      w = ECALL_W;
         default: w = {25'(pick(32'h0200_0000)), 7'h13};                   // op-imm
      endcase
      return w;
   endfunction

   // ------------------------------
   // reference model
   // ------------------------------
   task automatic ras_push(input logic [PC_SZ-1:0] addr);
      ras_model[ras_ptr] = addr;
      ras_ptr = ras_ptr + 1'b1;
   endtask

   task automatic model_step(output logic [31:0] e_pc, output logic [31:0] e_instr,
                             output logic [31:0] e_pred);
      logic [31:0]      w, seq, b_off, j_off, i_off;
      logic [4:0]       rd, rs1;
      logic             rd_link, rs1_link;
      logic [RP_SZ-1:0] top;
      w        = prog[model_pc[9:2]];               // memory repeats every 1 KB
      seq      = model_pc + 32'd4;
      e_pred   = seq;
      rd       = w[11:7];
      rs1      = w[19:15];
      rd_link  = (rd == 5'd1) || (rd == 5'd5);
      rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);
      top      = ras_ptr - 1'b1;
      b_off    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      j_off    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      i_off    = {{20{w[31]}}, w[31:20]};
      if (w[6:0] == 7'h63)
      begin
         if (b_off[31])
            e_pred = model_pc + b_off;              // backward taken
      end
      else if (w[6:0] == 7'h6f)
      begin
         e_pred = model_pc + j_off;
         if (rd_link)
            ras_push(seq);
      end
      else if ((w[6:0] == 7'h67) && (w[14:12] == 3'b000))
      begin
         e_pred = i_off;                            // base taken as x0
         if (rd_link && rs1_link && (rd != rs1))
            ras_model[top] = seq;                   // pop then push
         else if (rd_link)
            ras_push(seq);
         else if (rs1_link)
            ras_ptr = top;
      end
      else if (w == MRET_W)
      begin
         e_pred  = ras_model[top];
         ras_ptr = top;
      end
      else if ((w == ECALL_W) || (w == EBREAK_W))
         e_pred = `FETCH_TRAP_VECTOR;
      e_pc     = model_pc;
      e_instr  = w;
      model_pc = e_pred;
   endtask

   task automatic compare(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("CHECK FAILED %s: actual %h expected %h (entry %0d)",
                  name, actual, expected, entries);
      end
   endtask

   task automatic check_entry();
      logic [31:0] e_pc, e_instr, e_pred;
      model_step(e_pc, e_instr, e_pred);
      compare("f2d_entry.pc", f2d_entry.pc, e_pc);
      compare("f2d_entry.instruction", f2d_entry.instruction, e_instr);
      compare("f2d_entry.predicted_addr", f2d_entry.predicted_addr, e_pred);
   endtask

   // ------------------------------
   // cache and decode side
   // ------------------------------
   task automatic respond_to_cache();
      if (ic_ack)
         ic_ack = 1'b0;                             // transfer done on this edge
      else if (ic_req && !draining)
      begin
         if (ack_delay < 0)
            ack_delay = int'(pick(4));              // 0..3 wait cycles
         if (ack_delay == 0)
         begin
            for (int s = 0; s < `FETCH_MAX_IPCL; s++)
               ic_line[s*32 +: 32] = prog[{ic_addr[9:5], 3'(s)}];
            ic_ack    = 1'b1;
            ack_delay = -1;
         end
         else
            ack_delay--;
      end
   endtask

   task automatic drive_decode();
      pc_reload = 1'b0;
      if (halt_left > 0)
      begin
         cpu_halt = 1'b1;
         halt_left--;
      end
      else
      begin
         cpu_halt = 1'b0;
         if (pick(16) == 0)
            halt_left = 1 + int'(pick(6));
      end
      f2d_rdy = draining ? 1'b1 : (pick(10) < 7);   // 70 % ready
      // redirect once every accepted line has been drained and checked
      if (draining && !f2d_valid)
      begin
         pc_reload      = 1'b1;
         pc_reload_addr = 32'(pick(MEM_WORDS)) << 2;
         model_pc       = pc_reload_addr;           // stack kept as is
         draining       = 1'b0;
         next_reload    = entries + RELOAD_GAP;
      end
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial
   begin
      clk_in         = 1'b0;
      reset_in       = 1'b1;
      cpu_halt       = 1'b0;
      pc_reload      = 1'b0;
      pc_reload_addr = '0;
      ic_ack         = 1'b0;
      ic_line        = '0;
      f2d_rdy        = 1'b0;
      seed           = SEED;
      errors         = 0;
      checks         = 0;
      entries        = 0;
      cycles         = 0;
      ack_delay      = -1;
      halt_left      = 0;
      next_reload    = RELOAD_GAP;
      draining       = 1'b0;
      timed_out      = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++)
         prog[i] = make_word(i);
      model_pc = `FETCH_RESET_VECTOR;
      ras_ptr  = '0;
      for (int i = 0; i < `FETCH_RAS_DEPTH; i++)
         ras_model[i] = '0;                         // stack clears on reset

      repeat (RESET_CYC) @(posedge clk_in);
      #DRIVE_DLY reset_in = 1'b0;

      while ((entries < N_ENTRIES) && !timed_out)
      begin
         @(posedge clk_in);
         cycles++;
         #DRIVE_DLY;
         respond_to_cache();
         drive_decode();
         @(negedge clk_in);                         // outputs settled for this cycle
         if (f2d_valid && f2d_rdy)
         begin
            check_entry();
            entries++;
         end
         if (!draining && (entries >= next_reload))
            draining = 1'b1;                        // hold acks, drain, then redirect
         if (cycles >= CYCLE_LIMIT)
            timed_out = 1'b1;
      end

      if (timed_out)
      begin
         $display("timeout: only %0d of %0d entries seen in %0d cycles",
                  entries, N_ENTRIES, cycles);
         errors++;
      end
      $display("fetch_unit_tb: %0d entries, %0d checks, %0d errors, %0d assertion failures",
               entries, checks, errors, u_fetch_unit.u_checker.assert_fails);
      if ((errors == 0) && (u_fetch_unit.u_checker.assert_fails == 0))
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
